//--- source/ray_settings.svh
`ifndef RAY_SETTINGS_SVH
`define RAY_SETTINGS_SVH

// geometry widths
`define RAY_COORD_W      16
`define RAY_SCALAR_W     64

`define RAY_NUM_THREAD   32
`define RAY_NUM_TRIANGLE 512
`define RAY_CALC_LATENCY 4   // isect_calc depth

`endif

//--- source/ray_geom_pkg.sv
`include "ray_settings.svh"

package ray_geom_pkg;

  // signed integer coordinate
  typedef logic signed [`RAY_COORD_W-1:0] coord_t;

  typedef struct packed {
    coord_t x;
    coord_t y;
    coord_t z;
  } vec3_t;

  // dot and cross results
  typedef logic signed [`RAY_SCALAR_W-1:0] scalar_t;

  typedef struct packed {
    scalar_t x;
    scalar_t y;
    scalar_t z;
  } svec3_t;

endpackage

//--- source/ray_ctrl_pkg.sv
`include "ray_settings.svh"

package ray_ctrl_pkg;

  typedef logic [$clog2(`RAY_NUM_THREAD)-1:0] thread_id_t;
  typedef logic [$clog2(`RAY_NUM_TRIANGLE)-1:0] tri_index_t;

  typedef logic [31:0] sid_t;   // surface id

  // SEARCH means no hit stored yet
  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    SEARCH = 2'd1,
    REFINE = 2'd2
  } ctrl_state_t;

endpackage

//--- source/tri_fetch.sv
`include "ray_settings.svh"

module tri_fetch
  import ray_geom_pkg::*, ray_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       start,
  input  logic       fetch,
  input  logic       tri_ack,
  input  logic       tri_end,
  input  vec3_t      tri_v0,
  input  vec3_t      tri_v1,
  input  vec3_t      tri_v2,
  input  sid_t       tri_sid,
  output logic       tri_req,
  output tri_index_t tri_index,
  output logic       tri_valid,
  output logic       list_end,
  output vec3_t      v0,
  output vec3_t      v1,
  output vec3_t      v2,
  output sid_t       sid
);

  logic got_tri;
  logic got_end;

  assign got_tri = tri_req & tri_ack;
  assign got_end = tri_req & tri_end;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      tri_req   <= 1'b0;
      tri_index <= '0;
      tri_valid <= 1'b0;
      list_end  <= 1'b0;
    end else begin
      tri_valid <= got_tri;
      list_end  <= got_end;
      if (start)
        tri_index <= '0;   // new ray, restart at first triangle
      else if (got_tri)
        tri_index <= tri_index + 1'b1;
      // hold request until the memory answers
      if (got_tri | got_end)
        tri_req <= 1'b0;
      else if (fetch)
        tri_req <= 1'b1;
    end
  end

  // triangle capture
  always_ff @(posedge clk) begin
    if (got_tri) begin
      v0  <= tri_v0;
      v1  <= tri_v1;
      v2  <= tri_v2;
      sid <= tri_sid;
    end
  end

endmodule

//--- source/isect_calc.sv
`include "ray_settings.svh"

module isect_calc
  import ray_geom_pkg::*, ray_ctrl_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  vec3_t   orig,
  input  vec3_t   dir,
  input  vec3_t   v0,
  input  vec3_t   v1,
  input  vec3_t   v2,
  input  sid_t    sid_in,
  output logic    hit,
  output scalar_t t_num,
  output scalar_t det,
  output svec3_t  norm,
  output sid_t    sid_out
);

  function automatic svec3_t vsub(input vec3_t a, input vec3_t b);
    svec3_t r;
    r.x = scalar_t'(a.x) - scalar_t'(b.x);
    r.y = scalar_t'(a.y) - scalar_t'(b.y);
    r.z = scalar_t'(a.z) - scalar_t'(b.z);
    return r;
  endfunction

  function automatic svec3_t cross_prod(input svec3_t a, input svec3_t b);
    svec3_t r;
    r.x = a.y * b.z - a.z * b.y;
    r.y = a.z * b.x - a.x * b.z;
    r.z = a.x * b.y - a.y * b.x;
    return r;
  endfunction

  function automatic scalar_t dot(input svec3_t a, input svec3_t b);
    scalar_t r;
    r = a.x * b.x + a.y * b.y + a.z * b.z;
    return r;
  endfunction

  // stage 1
  svec3_t  e1_s1, e2_s1, tvec_s1, dir_s1;
  sid_t    sid_s1;
  // stage 2
  svec3_t  pvec_s2, qvec_s2, norm_s2, e1_s2, e2_s2, tvec_s2, dir_s2;
  sid_t    sid_s2;
  // stage 3
  scalar_t det_s3, u_s3, v_s3, t_s3;
  svec3_t  norm_s3;
  sid_t    sid_s3;

  always_ff @(posedge clk) begin
    // edges and origin offset
    e1_s1   <= vsub(v1, v0);
    e2_s1   <= vsub(v2, v0);
    tvec_s1 <= vsub(orig, v0);
    dir_s1  <= vsub(dir, '0);
    sid_s1  <= sid_in;

    pvec_s2 <= cross_prod(dir_s1, e2_s1);
    qvec_s2 <= cross_prod(tvec_s1, e1_s1);
    norm_s2 <= cross_prod(e1_s1, e2_s1);
    e1_s2   <= e1_s1;
    e2_s2   <= e2_s1;
    tvec_s2 <= tvec_s1;
    dir_s2  <= dir_s1;
    sid_s2  <= sid_s1;

    det_s3  <= dot(e1_s2, pvec_s2);
    u_s3    <= dot(tvec_s2, pvec_s2);   // barycentric u scaled by det
    v_s3    <= dot(dir_s2, qvec_s2);
    t_s3    <= dot(e2_s2, qvec_s2);
    norm_s3 <= norm_s2;
    sid_s3  <= sid_s2;

    t_num   <= t_s3;
    det     <= det_s3;
    norm    <= norm_s3;
    sid_out <= sid_s3;
  end

  // one-sided culling keeps front faces only
  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      hit <= 1'b0;
    else
      hit <= (det_s3 > 0) && (u_s3 >= 0) && (v_s3 >= 0) &&
             (u_s3 + v_s3 <= det_s3) && (t_s3 > 0);
  end

endmodule

//--- source/dist_less.sv
`include "ray_settings.svh"

module dist_less
  import ray_geom_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  scalar_t t_num_a,
  input  scalar_t det_a,
  input  scalar_t t_num_b,
  input  scalar_t det_b,
  output logic    less
);

  localparam int PROD_W = 2 * `RAY_SCALAR_W;

  // t_a/det_a < t_b/det_b with both dets positive
  logic signed [PROD_W-1:0] prod_a;
  logic signed [PROD_W-1:0] prod_b;

  assign prod_a = t_num_a * det_b;
  assign prod_b = t_num_b * det_a;

  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      less <= 1'b0;
    else
      less <= (prod_a < prod_b);   // strict, ties keep the older hit
  end

endmodule

//--- source/isect_ctrl.sv
`include "ray_settings.svh"

module isect_ctrl
  import ray_geom_pkg::*, ray_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       ray_valid,
  input  thread_id_t thread_id_in,
  input  vec3_t      ray_orig,
  input  vec3_t      ray_dir,
  input  logic       tri_valid,
  input  logic       list_end,
  input  logic       hit,
  input  logic       less,
  input  scalar_t    t_num,
  input  scalar_t    det,
  input  svec3_t     norm,
  input  sid_t       sid,
  output logic       ray_ready,
  output logic       start,
  output logic       fetch,
  output vec3_t      orig,
  output vec3_t      dir,
  output scalar_t    best_t_num,
  output scalar_t    best_det,
  output logic       result_valid,
  output thread_id_t thread_id_out,
  output logic       result_hit,
  output sid_t       result_sid,
  output scalar_t    result_t_num,
  output scalar_t    result_det,
  output svec3_t     result_norm
);

  localparam int EVAL_CNT = `RAY_CALC_LATENCY + 1;   // pipeline plus compare
  localparam int CNT_W    = $clog2(EVAL_CNT + 1);

  ctrl_state_t      state;
  logic [CNT_W-1:0] lat_cnt;
  thread_id_t       thread_q;
  sid_t             best_sid;
  svec3_t           best_norm;
  logic             eval;
  logic             take;

  assign ray_ready = (state == IDLE);
  assign start     = ray_ready & ray_valid;
  assign eval      = (lat_cnt == CNT_W'(EVAL_CNT));
  // first hit always wins, later ones only if strictly nearer
  assign take      = eval & hit & ((state == SEARCH) | less);

  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      lat_cnt <= '0;
    else if (tri_valid)
      lat_cnt <= CNT_W'(1);
    else if (eval)
      lat_cnt <= '0;
    else if (lat_cnt != '0)
      lat_cnt <= lat_cnt + 1'b1;
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state        <= IDLE;
      fetch        <= 1'b0;
      result_valid <= 1'b0;
    end else begin
      fetch        <= start | eval;   // next triangle after each verdict
      result_valid <= 1'b0;
      case (state)
        IDLE:
          if (ray_valid)
            state <= SEARCH;
        SEARCH, REFINE:
          if (list_end) begin
            state        <= IDLE;
            result_valid <= 1'b1;
          end else if (take) begin
            state <= REFINE;
          end
        default:
          state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      orig     <= ray_orig;
      dir      <= ray_dir;
      thread_q <= thread_id_in;
    end
  end

  // nearest hit so far
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      best_t_num <= '0;
      best_det   <= '0;
      best_sid   <= '0;
      best_norm  <= '0;
    end else if (start) begin
      best_t_num <= '0;
      best_det   <= '0;
      best_sid   <= '0;
      best_norm  <= '0;
    end else if (take) begin
      best_t_num <= t_num;
      best_det   <= det;
      best_sid   <= sid;
      best_norm  <= norm;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      thread_id_out <= '0;
      result_hit    <= 1'b0;
      result_sid    <= '0;
      result_t_num  <= '0;
      result_det    <= '0;
      result_norm   <= '0;
    end else if (list_end && state != IDLE) begin
      thread_id_out <= thread_q;
      result_hit    <= (state == REFINE);
      result_sid    <= best_sid;
      result_t_num  <= best_t_num;
      result_det    <= best_det;
      result_norm   <= best_norm;
    end
  end

endmodule

//--- source/ray_intersect_core.sv
`include "ray_settings.svh"

module ray_intersect_core
  import ray_geom_pkg::*, ray_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  // ray input
  input  logic       ray_valid,
  output logic       ray_ready,
  input  thread_id_t thread_id_in,
  input  vec3_t      ray_orig,
  input  vec3_t      ray_dir,
  // triangle memory
  output logic       tri_req,
  output tri_index_t tri_index,
  input  logic       tri_ack,
  input  logic       tri_end,
  input  vec3_t      tri_v0,
  input  vec3_t      tri_v1,
  input  vec3_t      tri_v2,
  input  sid_t       tri_sid,
  // result
  output logic       result_valid,
  output thread_id_t thread_id_out,
  output logic       result_hit,
  output sid_t       result_sid,
  output scalar_t    result_t_num,
  output scalar_t    result_det,
  output svec3_t     result_norm
);

  logic    start, fetch, tri_valid, list_end;
  logic    hit, less;
  vec3_t   v0, v1, v2, orig, dir;
  sid_t    tri_sid_q, calc_sid;
  scalar_t t_num, det, best_t_num, best_det;
  svec3_t  norm;

  tri_fetch tri_fetch_i (
    .clk(clk), .rst(rst), .start(start), .fetch(fetch),
    .tri_ack(tri_ack), .tri_end(tri_end),
    .tri_v0(tri_v0), .tri_v1(tri_v1), .tri_v2(tri_v2), .tri_sid(tri_sid),
    .tri_req(tri_req), .tri_index(tri_index),
    .tri_valid(tri_valid), .list_end(list_end),
    .v0(v0), .v1(v1), .v2(v2), .sid(tri_sid_q)
  );

  isect_calc isect_calc_i (
    .clk(clk), .rst(rst), .orig(orig), .dir(dir),
    .v0(v0), .v1(v1), .v2(v2), .sid_in(tri_sid_q),
    .hit(hit), .t_num(t_num), .det(det), .norm(norm), .sid_out(calc_sid)
  );

  dist_less dist_less_i (
    .clk(clk), .rst(rst),
    .t_num_a(t_num), .det_a(det), .t_num_b(best_t_num), .det_b(best_det),
    .less(less)
  );

  isect_ctrl isect_ctrl_i (
    .clk(clk), .rst(rst), .ray_valid(ray_valid), .thread_id_in(thread_id_in),
    .ray_orig(ray_orig), .ray_dir(ray_dir),
    .tri_valid(tri_valid), .list_end(list_end),
    .hit(hit), .less(less), .t_num(t_num), .det(det), .norm(norm), .sid(calc_sid),
    .ray_ready(ray_ready), .start(start), .fetch(fetch), .orig(orig), .dir(dir),
    .best_t_num(best_t_num), .best_det(best_det),
    .result_valid(result_valid), .thread_id_out(thread_id_out),
    .result_hit(result_hit), .result_sid(result_sid),
    .result_t_num(result_t_num), .result_det(result_det), .result_norm(result_norm)
  );

endmodule

//--- dv/tri_mem_model.sv
module tri_mem_model
  import ray_geom_pkg::*, ray_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       tri_req,
  input  tri_index_t tri_index,
  output logic       tri_ack,
  output logic       tri_end,
  output vec3_t      tri_v0,
  output vec3_t      tri_v1,
  output vec3_t      tri_v2,
  output sid_t       tri_sid
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int MAX_TRI = 16;

  vec3_t mem_v0 [MAX_TRI];
  vec3_t mem_v1 [MAX_TRI];
  vec3_t mem_v2 [MAX_TRI];
  sid_t  mem_sid [MAX_TRI];
  int    mem_lat [MAX_TRI + 1];   // slot list_len holds the end-of-list latency
  int    list_len = 0;
  int    wait_cnt;

  task automatic load_tri(input int i, input vec3_t a, input vec3_t b, input vec3_t c,
                          input sid_t s, input int lat);
    mem_v0[i]  = a;
    mem_v1[i]  = b;
    mem_v2[i]  = c;
    mem_sid[i] = s;
    mem_lat[i] = lat;
  endtask

  task automatic set_list(input int len, input int end_lat);
    list_len      = len;
    mem_lat[len]  = end_lat;
  endtask

  // answers on the falling edge, one cycle pulse
  always @(negedge clk or posedge rst) begin
    if (rst) begin
      tri_ack  <= 1'b0;
      tri_end  <= 1'b0;
      tri_v0   <= '0;
      tri_v1   <= '0;
      tri_v2   <= '0;
      tri_sid  <= '0;
      wait_cnt <= 0;
    end else begin
      tri_ack <= 1'b0;
      tri_end <= 1'b0;
      if (tri_req && !tri_ack && !tri_end) begin
        if (int'(tri_index) >= list_len) begin
          if (wait_cnt >= mem_lat[list_len]) begin
            tri_end  <= 1'b1;
            wait_cnt <= 0;
          end else
            wait_cnt <= wait_cnt + 1;
        end else if (wait_cnt >= mem_lat[tri_index]) begin
          tri_ack  <= 1'b1;
          tri_v0   <= mem_v0[tri_index];
          tri_v1   <= mem_v1[tri_index];
          tri_v2   <= mem_v2[tri_index];
          tri_sid  <= mem_sid[tri_index];
          wait_cnt <= 0;
        end else
          wait_cnt <= wait_cnt + 1;   // still busy
      end
    end
  end

endmodule

//--- dv/tb_ray_intersect.sv
`include "ray_settings.svh"

module tb_ray_intersect
  import ray_geom_pkg::*, ray_ctrl_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD = 8;
  localparam int MAX_LEN    = 12;
  localparam int NUM_RAND   = 30;
  localparam int NUM_BACK   = 10;
  localparam int NUM_ORDER  = 4;
  localparam int NUM_RAYS   = NUM_RAND + NUM_BACK + NUM_ORDER + 4;
  // every triangle and the list end cost memory latency plus the pipeline walk
  localparam longint WATCHDOG_CYC =
    NUM_RAYS * (MAX_LEN + 1) * (`RAY_CALC_LATENCY + 10) + 500;

  logic       clk = 1'b0;
  logic       rst;
  logic       ray_valid, ray_ready;
  thread_id_t thread_id_in, thread_id_out, exp_thread;
  vec3_t      ray_orig, ray_dir, tri_v0, tri_v1, tri_v2;
  logic       tri_req, tri_ack, tri_end;
  tri_index_t tri_index;
  sid_t       tri_sid, result_sid, exp_sid;
  logic       result_valid, result_hit, exp_hit;
  scalar_t    result_t_num, result_det, exp_tn, exp_det;
  svec3_t     result_norm, exp_norm;

  int unsigned lcg_state = 70;
  int          checks = 0;
  int          errors = 0;
  int          acks_seen = 0;
  logic        prev_req = 1'b0;
  vec3_t       cur_orig, cur_dir;
  vec3_t       tv0 [MAX_LEN];
  vec3_t       tv1 [MAX_LEN];
  vec3_t       tv2 [MAX_LEN];
  sid_t        tsid [MAX_LEN];

  ray_intersect_core ray_intersect_core_i (.*);
  tri_mem_model tri_mem_model_i (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic int lcg_range(input int lo, input int hi);
    lcg_state = lcg_state * 1664525 + 1013904223;
    return lo + int'((lcg_state >> 8) % (hi - lo + 1));
  endfunction

  function automatic vec3_t lcg_vec(input int lim);
    vec3_t r;
    r.x = coord_t'(lcg_range(-lim, lim));
    r.y = coord_t'(lcg_range(-lim, lim));
    r.z = coord_t'(lcg_range(-lim, lim));
    return r;
  endfunction

  function automatic vec3_t vadd(input vec3_t a, input vec3_t b, input int s);
    vec3_t r;
    r.x = a.x + s * b.x;
    r.y = a.y + s * b.y;
    r.z = a.z + s * b.z;
    return r;
  endfunction

  function automatic longint axis(input vec3_t w, input int k);
    return (k == 0) ? w.x : ((k == 1) ? w.y : w.z);
  endfunction

  task automatic check_value(input string name, input logic [191:0] actual,
                             input logic [191:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("MISMATCH %s: got %0h expected %0h", name, actual, expected);
    end
  endtask

  // integer ray test, one-sided, t = tn / dt
  task automatic ref_triangle(input vec3_t a, input vec3_t b, input vec3_t c,
                              output logic hit, output scalar_t tn, output scalar_t dt,
                              output svec3_t nrm);
    longint d[3], e1[3], e2[3], tv[3], pv[3], qv[3], nv[3];
    longint det_l, u, v, t_l;
    for (int k = 0; k < 3; k++) begin
      e1[k] = axis(b, k) - axis(a, k);
      e2[k] = axis(c, k) - axis(a, k);
      tv[k] = axis(cur_orig, k) - axis(a, k);
      d[k]  = axis(cur_dir, k);
    end
    for (int k = 0; k < 3; k++) begin
      pv[k] = d[(k+1)%3] * e2[(k+2)%3] - d[(k+2)%3] * e2[(k+1)%3];
      qv[k] = tv[(k+1)%3] * e1[(k+2)%3] - tv[(k+2)%3] * e1[(k+1)%3];
      nv[k] = e1[(k+1)%3] * e2[(k+2)%3] - e1[(k+2)%3] * e2[(k+1)%3];
    end
    det_l = 0;
    u = 0;
    v = 0;
    t_l = 0;
    for (int k = 0; k < 3; k++) begin
      det_l += e1[k] * pv[k];
      u     += tv[k] * pv[k];
      v     += d[k] * qv[k];
      t_l   += e2[k] * qv[k];
    end
    hit = (det_l > 0) && (u >= 0) && (v >= 0) && (u + v <= det_l) && (t_l > 0);
    tn  = t_l;
    dt  = det_l;
    nrm = '{nv[0], nv[1], nv[2]};
  endtask

  // mode 0 mixes all kinds, mode 1 only back faces and hits behind the origin
  task automatic build_list(input int len, input int mode, input int base);
    vec3_t   p, r0, r1, tmp;
    int      kind, step;
    logic    h;
    scalar_t tn, dt;
    svec3_t  n;
    for (int i = 0; i < len; i++) begin
      kind = (mode == 1) ? lcg_range(1, 2) : lcg_range(0, 3);
      if (kind == 0 || (kind == 3 && i == 0)) begin
        tv0[i] = lcg_vec(127);
        tv1[i] = lcg_vec(127);
        tv2[i] = lcg_vec(127);
      end else if (kind == 3) begin
        tv0[i] = tv0[i-1];   // same distance, earlier one must win
        tv1[i] = tv1[i-1];
        tv2[i] = tv2[i-1];
      end else begin
        step = (kind == 1) ? lcg_range(1, 3) : lcg_range(-3, -1);
        p  = vadd(cur_orig, cur_dir, step);
        r0 = lcg_vec(12);
        r1 = lcg_vec(12);
        tv0[i] = vadd(p, r0, 1);   // p is the centroid
        tv1[i] = vadd(p, r1, 1);
        tv2[i] = vadd(vadd(p, r0, -1), r1, -1);
        if (lcg_range(0, 1) == 1) begin
          tmp    = tv1[i];
          tv1[i] = tv2[i];
          tv2[i] = tmp;
        end
      end
      ref_triangle(tv0[i], tv1[i], tv2[i], h, tn, dt, n);
      if (mode == 1 && h) begin
        tmp    = tv1[i];   // flip winding so it faces away
        tv1[i] = tv2[i];
        tv2[i] = tmp;
      end
      tsid[i] = base + i;
      tri_mem_model_i.load_tri(i, tv0[i], tv1[i], tv2[i], tsid[i], lcg_range(0, 5));
    end
  endtask

  task automatic predict_nearest(input int len);
    logic    h;
    scalar_t tn, dt;
    svec3_t  n;
    exp_hit  = 1'b0;
    exp_sid  = '0;
    exp_tn   = '0;
    exp_det  = '0;
    exp_norm = '0;
    for (int i = 0; i < len; i++) begin
      ref_triangle(tv0[i], tv1[i], tv2[i], h, tn, dt, n);
      if (h && (!exp_hit || tn * exp_det < exp_tn * dt)) begin
        exp_hit  = 1'b1;
        exp_sid  = tsid[i];
        exp_tn   = tn;
        exp_det  = dt;
        exp_norm = n;
      end
    end
  endtask

  task automatic check_result();
    check_value("thread_id_out", thread_id_out, exp_thread);
    check_value("result_hit", result_hit, exp_hit);
    check_value("result_sid", result_sid, exp_sid);
    check_value("result_t_num", result_t_num, exp_tn);
    check_value("result_det", result_det, exp_det);
    check_value("result_norm", result_norm, exp_norm);
  endtask

  task automatic run_ray(input int thread, input int len, input int mode, input int base);
    cur_orig = lcg_vec(40);
    cur_dir  = lcg_vec(20);
    build_list(len, mode, base);
    tri_mem_model_i.set_list(len, lcg_range(0, 5));
    predict_nearest(len);
    exp_thread = thread_id_t'(thread);
    while (!ray_ready)
      @(negedge clk);
    ray_valid    = 1'b1;
    thread_id_in = thread_id_t'(thread);
    ray_orig     = cur_orig;
    ray_dir      = cur_dir;
    acks_seen    = 0;
    @(negedge clk);
    ray_valid = 1'b0;
    while (!result_valid)
      @(negedge clk);
    check_result();
  endtask

  task automatic end_test(input int num, input string name, input int mark);
    $display("test %0d %s: %0d errors", num, name, errors - mark);
  endtask

  // tri_ack and tri_end read here are what the DUT saw at the last rising edge
  always @(negedge clk) begin
    if (!rst) begin
      if (tri_ack)
        acks_seen++;
      if (prev_req && !tri_ack && !tri_end)
        check_value("tri_req", tri_req, 1'b1);
      if (tri_req)
        check_value("tri_index", tri_index, acks_seen);
      prev_req = tri_req;
    end
  end

  initial begin
    int mark;
    rst          = 1'b1;
    ray_valid    = 1'b0;
    thread_id_in = '0;
    ray_orig     = '0;
    ray_dir      = '0;
    repeat (5) @(negedge clk);
    rst = 1'b0;

    mark = errors;
    check_value("ray_ready", ray_ready, 1'b1);
    check_value("tri_req", tri_req, 1'b0);
    check_value("result_valid", result_valid, 1'b0);
    check_value("result_t_num", result_t_num, '0);
    end_test(1, "reset state", mark);

    mark = errors;
    run_ray(5, 0, 0, 16);
    end_test(2, "empty list", mark);

    mark = errors;
    for (int n = 0; n < NUM_RAND; n++)
      run_ray(lcg_range(0, 31), lcg_range(0, MAX_LEN), 0, 256 * (n + 1));
    end_test(3, "random nearest hit", mark);

    mark = errors;
    for (int n = 0; n < NUM_BACK; n++) begin
      run_ray(n, lcg_range(1, MAX_LEN), 1, 'h10000 + 256 * n);
      check_value("result_hit", result_hit, 1'b0);
    end
    end_test(4, "back faces and behind origin", mark);

    mark = errors;
    for (int n = 0; n < NUM_ORDER; n++) begin
      run_ray(n + 20, MAX_LEN, 0, 'h20000 + 256 * n);
      check_value("tri_ack count", acks_seen, MAX_LEN);
    end
    end_test(5, "index order and request hold", mark);

    mark = errors;
    run_ray(3, 6, 0, 'h30000);
    run_ray(17, 6, 0, 'h30100);   // accepted right after the previous result
    repeat (4) begin
      @(negedge clk);
      check_value("result_valid", result_valid, 1'b0);
      check_result();
    end
    run_ray(9, 4, 0, 'h30200);
    end_test(6, "back-to-back threads", mark);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

  initial begin
    #(WATCHDOG_CYC * CLK_PERIOD);
    $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYC);
    $display("Done: errors found");
    $finish;
  end

endmodule

//--- filelist.f
+incdir+source
source/ray_geom_pkg.sv
source/ray_ctrl_pkg.sv
source/tri_fetch.sv
source/isect_calc.sv
source/dist_less.sv
source/isect_ctrl.sv
source/ray_intersect_core.sv
dv/tri_mem_model.sv
dv/tb_ray_intersect.sv

//--- Bender.yml
package:
  name: ray_intersect_core

sources:
  - include_dirs:
      - source
    files:
      - source/ray_geom_pkg.sv
      - source/ray_ctrl_pkg.sv
      - source/tri_fetch.sv
      - source/isect_calc.sv
      - source/dist_less.sv
      - source/isect_ctrl.sv
      - source/ray_intersect_core.sv
  - target: test
    include_dirs:
      - source
    files:
      - dv/tri_mem_model.sv
      - dv/tb_ray_intersect.sv
